//--- sim.f
hw/blimp_pkg.sv
hw/decode_issue.sv
hw/alu_unit.sv
hw/iterative_multiplier.sv
hw/writeback_commit.sv
hw/blimp_core.sv
verification/blimp_core_tb.sv

//--- verification/blimp_core_tb.sv
`timescale 1ns/10ps
// Testbench for the out-of-order core
// Clock and reset, LFSR stimulus, reference model of RV32I ALU ops and MUL
// In-order commit checker against a queue of expected commits

module blimp_core_tb
  import blimp_pkg::*;
();

  localparam int          issue_timeout = 100;
  localparam int          drain_timeout = 300;
  localparam logic [31:0] lfsr_taps     = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        inst_val;
  inst_u       inst;
  logic        inst_rdy;
  logic        commit_val;
  commit_msg_t commit_msg;

  logic [31:0] lfsr_q;
  // Architectural state in program order
  logic [31:0] tb_rf [num_arch_regs];
  // Sequence numbers follow program order
  logic [seq_num_bits-1:0] seq_cnt;
  commit_msg_t exp_q [$];
  string       name_q [$];
  string       test_name;
  int          mismatch_cnt;
  int          other_cnt;

  blimp_core dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_val   (inst_val),
    .inst       (inst),
    .inst_rdy   (inst_rdy),
    .commit_val (commit_val),
    .commit_msg (commit_msg)
  );

  always #5 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_taps) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  // Reference model over the testbench register file
  function automatic commit_msg_t expected_commit(input logic [31:0] w);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [63:0] prod;
    logic        legal;
    logic        r_type;
    commit_msg_t m;
    opc    = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    r_type = (opc == opc_op);
    a      = tb_rf[w[19:15]];
    // Sign-extended immediate with shamt in the low five bits
    b      = r_type ? tb_rf[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (r_type) begin
      legal = (f7 == 7'h00) || ((f7 == funct7_muldiv) && (f3 == 3'd0)) ||
              ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
    end else if (opc == opc_op_imm) begin
      legal = (f3 == 3'd1) ? (f7 == 7'h00) :
              (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
    end else begin
      legal = 1'b0;
    end
    case (f3)
      3'd0: begin
        prod = {32'b0, a} * {32'b0, b};
        if (r_type && (f7 == funct7_muldiv)) d = prod[31:0];
        else if (r_type && f7[5]) d = a - b;
        else d = a + b;
      end
      3'd1:    d = a << b[4:0];
      3'd2:    d = {31'b0, $signed(a) < $signed(b)};
      3'd3:    d = {31'b0, a < b};
      3'd4:    d = a ^ b;
      3'd5:    d = f7[5] ? 32'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
      3'd6:    d = a | b;
      default: d = a & b;
    endcase
    m       = '0;
    m.waddr = w[11:7];
    m.wen   = legal && (w[11:7] != 5'd0);
    m.wdata = legal ? d : 32'b0;
    return m;
  endfunction

  // Drive at the falling edge and sample ready just after it
  task automatic issue_inst(input logic [31:0] w);
    int          waited;
    commit_msg_t m;
    waited   = 0;
    inst     = w;
    inst_val = 1'b1;
    #1;
    while (!inst_rdy && waited < issue_timeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    assert (inst_rdy) else begin
      $display("Timeout: instruction %h not accepted in test %s", w, test_name);
      other_cnt++;
    end
    if (inst_rdy) begin
      m       = expected_commit(w);
      m.seq   = seq_cnt;
      seq_cnt = seq_cnt + 1'b1;
      exp_q.push_back(m);
      name_q.push_back(test_name);
      if (m.wen) tb_rf[m.waddr] = m.wdata;
    end
    @(negedge clk);
    inst_val = 1'b0;
  endtask

  task automatic drain_commits();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("Timeout: %0d commits never arrived in test %s", exp_q.size(), test_name);
      other_cnt++;
    end
  endtask

  // --------------------
  // Commit checker
  // --------------------

  always @(negedge clk) begin : check_commits
    commit_msg_t e;
    string       n;
    if (rst_n && commit_val) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected commit to x%0d with nothing outstanding", commit_msg.waddr);
        other_cnt++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        assert (commit_msg.seq == e.seq) else begin
          $display("MISMATCH %s seq: expected %0d, actual %0d", n, e.seq, commit_msg.seq);
          mismatch_cnt++;
        end
        assert (commit_msg.waddr == e.waddr) else begin
          $display("MISMATCH %s waddr: expected %0d, actual %0d", n, e.waddr, commit_msg.waddr);
          mismatch_cnt++;
        end
        assert (commit_msg.wen == e.wen) else begin
          $display("MISMATCH %s wen: expected %0b, actual %0b", n, e.wen, commit_msg.wen);
          mismatch_cnt++;
        end
        // Data only matters when the register is written
        assert (!e.wen || commit_msg.wdata == e.wdata) else begin
          $display("MISMATCH %s wdata: expected %h, actual %h", n, e.wdata, commit_msg.wdata);
          mismatch_cnt++;
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  initial begin : run_tests
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic        alt;
    clk          = 1'b0;
    rst_n        = 1'b0;
    inst_val     = 1'b0;
    inst         = '0;
    lfsr_q       = 32'd59;
    seq_cnt      = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    test_name    = "reset";
    for (int i = 0; i < num_arch_regs; i++) tb_rf[i] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (inst_rdy && !commit_val) else begin
      $display("After reset inst_rdy is low or commit_val is high");
      other_cnt++;
    end
    @(negedge clk);

    // ADDI loads of extremes then random values
    test_name = "addi_load";
    issue_inst(encode_i(12'hfff, 5'd0, 3'd0, 5'd1));
    issue_inst(encode_i(12'h7ff, 5'd0, 3'd0, 5'd2));
    issue_inst(encode_i(12'h800, 5'd0, 3'd0, 5'd3));
    for (int r = 4; r < 16; r++) issue_inst(encode_i(12'(lfsr_bits(12)), 5'd0, 3'd0, 5'(r)));
    drain_commits();

    test_name = "alu_random";
    for (int k = 0; k < 80; k++) begin
      rd  = 5'(lfsr_bits(4));
      if (rd == 5'd0) rd = 5'd7;
      rs1 = 5'(lfsr_bits(4));
      rs2 = 5'(lfsr_bits(4));
      f3  = 3'(lfsr_bits(3));
      alt = lfsr_bits(1) != 0;
      if (lfsr_bits(1) != 0) begin
        f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        issue_inst(encode_r(f7, rs2, rs1, f3, rd));
      end else begin
        imm = 12'(lfsr_bits(12));
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        else if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;
        issue_inst(encode_i(imm, rs1, f3, rd));
      end
    end
    drain_commits();

    // Operands widened by a shift with signs from the immediate
    test_name = "mul_random";
    for (int k = 0; k < 8; k++) begin
      issue_inst(encode_i(12'(lfsr_bits(12)), 5'd0, 3'd0, 5'd10));
      issue_inst(encode_i(12'(lfsr_bits(4)), 5'd10, 3'd1, 5'd10));
      issue_inst(encode_i(12'(lfsr_bits(12)), 5'd0, 3'd0, 5'd11));
      issue_inst(encode_r(funct7_muldiv, 5'd11, 5'd10, 3'd0, 5'd12));
      issue_inst(encode_r(funct7_muldiv, 5'(lfsr_bits(4)), 5'd12, 3'd0, 5'd13));
    end
    drain_commits();

    // Younger ALU ops wait behind the MUL
    test_name = "mul_order";
    issue_inst(encode_r(funct7_muldiv, 5'd11, 5'd10, 3'd0, 5'd13));
    for (int r = 14; r < 18; r++) issue_inst(encode_i(12'(lfsr_bits(12)), 5'(r - 10), 3'd0, 5'(r)));
    issue_inst(encode_r(7'h00, 5'd14, 5'd13, 3'd0, 5'd18));
    issue_inst(encode_r(funct7_muldiv, 5'd13, 5'd18, 3'd0, 5'd19));
    drain_commits();

    test_name = "x0_write";
    issue_inst(encode_i(12'd77, 5'd5, 3'd0, 5'd0));
    issue_inst(encode_r(funct7_muldiv, 5'd2, 5'd1, 3'd0, 5'd0));
    issue_inst(encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd20));
    issue_inst(encode_i(12'd5, 5'd0, 3'd6, 5'd21));
    drain_commits();

    // Load opcode, bad funct7, bad SLLI upper bits
    test_name = "illegal";
    issue_inst(encode_i(12'd123, 5'd0, 3'd0, 5'd22));
    issue_inst({12'h0ab, 5'd1, 3'd2, 5'd22, 7'b0000011});
    issue_inst(encode_r(7'h02, 5'd2, 5'd1, 3'd0, 5'd22));
    issue_inst(encode_i(12'h400, 5'd1, 3'd1, 5'd22));
    issue_inst(encode_r(7'h00, 5'd0, 5'd22, 3'd0, 5'd23));
    drain_commits();

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- hw/blimp_core.sv
`timescale 1ns/10ps
// Top level of the out-of-order core
// Decode/issue, ALU, multiplier and reorder buffer wired together

module blimp_core
  import blimp_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inst_val,
  input  inst_u       inst,
  output logic        inst_rdy,
  output logic        commit_val,
  output commit_msg_t commit_msg
);

  // --------------------
  // Stage links
  // --------------------

  logic     alu_val;
  d_x_msg_t alu_msg;
  logic     mul_val;
  d_x_msg_t mul_msg;
  logic     mul_rdy;
  logic     alu_w_val;
  x_w_msg_t alu_w_msg;
  logic     mul_w_val;
  x_w_msg_t mul_w_msg;

  // --------------------
  // Units
  // --------------------

  decode_issue diu (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_val   (inst_val),
    .inst       (inst),
    .inst_rdy   (inst_rdy),
    .mul_rdy    (mul_rdy),
    .commit_val (commit_val),
    .commit_msg (commit_msg),
    .alu_val    (alu_val),
    .alu_msg    (alu_msg),
    .mul_val    (mul_val),
    .mul_msg    (mul_msg)
  );

  alu_unit alu_xu (
    .clk   (clk),
    .rst_n (rst_n),
    .d_val (alu_val),
    .d_msg (alu_msg),
    .w_val (alu_w_val),
    .w_msg (alu_w_msg)
  );

  iterative_multiplier mul_xu (
    .clk   (clk),
    .rst_n (rst_n),
    .d_val (mul_val),
    .d_msg (mul_msg),
    .d_rdy (mul_rdy),
    .w_val (mul_w_val),
    .w_msg (mul_w_msg)
  );

  // Commit strobe doubles as the trace port
  writeback_commit wcu (
    .clk        (clk),
    .rst_n      (rst_n),
    .alu_w_val  (alu_w_val),
    .alu_w_msg  (alu_w_msg),
    .mul_w_val  (mul_w_val),
    .mul_w_msg  (mul_w_msg),
    .commit_val (commit_val),
    .commit_msg (commit_msg)
  );

endmodule

//--- hw/writeback_commit.sv
`timescale 1ns/10ps
// Reorder buffer for writeback and in-order commit
// Entries indexed by sequence number, one commit per cycle

module writeback_commit
  import blimp_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        alu_w_val,
  input  x_w_msg_t    alu_w_msg,
  input  logic        mul_w_val,
  input  x_w_msg_t    mul_w_msg,
  output logic        commit_val,
  output commit_msg_t commit_msg
);

  // --------------------
  // Entry storage
  // --------------------

  logic [rob_depth-1:0]     done_q;
  logic [rob_depth-1:0]     wen_q;
  logic [reg_addr_bits-1:0] waddr_q [rob_depth];
  logic [31:0]              wdata_q [rob_depth];
  logic [seq_num_bits-1:0]  head_q;

  // Head entry commits as soon as it is done
  always_comb begin
    commit_val       = done_q[head_q];
    commit_msg.seq   = head_q;
    commit_msg.waddr = waddr_q[head_q];
    commit_msg.wdata = wdata_q[head_q];
    commit_msg.wen   = wen_q[head_q];
  end

  // --------------------
  // Done flags and head
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
      head_q <= '0;
    end else begin
      if (commit_val) begin
        done_q[head_q] <= 1'b0;
        // Depth is a power of two, so the index wraps on its own
        head_q         <= head_q + 1'b1;
      end
      // Both pipes may finish together, always different entries
      if (alu_w_val) begin
        done_q[alu_w_msg.seq] <= 1'b1;
      end
      if (mul_w_val) begin
        done_q[mul_w_msg.seq] <= 1'b1;
      end
    end
  end

  // --------------------
  // Result capture
  // --------------------

  always_ff @(posedge clk) begin
    if (alu_w_val) begin
      waddr_q[alu_w_msg.seq] <= alu_w_msg.waddr;
      wdata_q[alu_w_msg.seq] <= alu_w_msg.wdata;
      wen_q[alu_w_msg.seq]   <= alu_w_msg.wen;
    end
    if (mul_w_val) begin
      waddr_q[mul_w_msg.seq] <= mul_w_msg.waddr;
      wdata_q[mul_w_msg.seq] <= mul_w_msg.wdata;
      wen_q[mul_w_msg.seq]   <= mul_w_msg.wen;
    end
  end

endmodule

//--- hw/iterative_multiplier.sv
`timescale 1ns/10ps
// Iterative shift-and-add multiplier pipe
// One multiplier bit per cycle, low 32 bits of the product

module iterative_multiplier
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     d_val,
  input  d_x_msg_t d_msg,
  output logic     d_rdy,
  output logic     w_val,
  output x_w_msg_t w_msg
);

  logic                     busy_q;
  logic [mul_cnt_bits-1:0]  cnt_q;
  logic                     w_val_q;
  logic [31:0]              mcand_q;
  logic [31:0]              mplier_q;
  logic [31:0]              acc_q;
  logic [31:0]              acc_next;
  logic [seq_num_bits-1:0]  seq_q;
  logic [reg_addr_bits-1:0] waddr_q;
  logic                     wen_q;
  logic                     start;

  assign d_rdy = !busy_q;
  assign start = d_val && !busy_q;
  // Low half is the same for signed and unsigned
  assign acc_next = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      w_val_q <= 1'b0;
    end else begin
      w_val_q <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last bit done, result strobes next cycle
        if (cnt_q == mul_cnt_bits'(mul_iters - 1)) begin
          busy_q  <= 1'b0;
          w_val_q <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // Datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q  <= d_msg.op_a;
      mplier_q <= d_msg.op_b;
      acc_q    <= '0;
      seq_q    <= d_msg.seq;
      waddr_q  <= d_msg.waddr;
      wen_q    <= d_msg.wen;
    end else if (busy_q) begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign w_val = w_val_q;
  assign w_msg = '{seq: seq_q, waddr: waddr_q, wdata: acc_q, wen: wen_q};

endmodule

//--- hw/alu_unit.sv
`timescale 1ns/10ps
// Single-cycle ALU execute pipe
// Ten RV32I integer ops, result registered with its tag

module alu_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     d_val,
  input  d_x_msg_t d_msg,
  output logic     w_val,
  output x_w_msg_t w_msg
);

  logic [31:0] result;
  logic [4:0]  shamt;
  logic        w_val_q;
  x_w_msg_t    w_msg_q;

  // --------------------
  // Datapath
  // --------------------

  always_comb begin
    // Shift amount from the low bits of op_b
    shamt = d_msg.op_b[4:0];
    case (d_msg.op)
      alu_add:  result = d_msg.op_a + d_msg.op_b;
      alu_sub:  result = d_msg.op_a - d_msg.op_b;
      alu_sll:  result = d_msg.op_a << shamt;
      alu_slt:  result = {31'b0, ($signed(d_msg.op_a) < $signed(d_msg.op_b))};
      alu_sltu: result = {31'b0, (d_msg.op_a < d_msg.op_b)};
      alu_xor:  result = d_msg.op_a ^ d_msg.op_b;
      alu_srl:  result = d_msg.op_a >> shamt;
      alu_sra:  result = $signed(d_msg.op_a) >>> shamt;
      alu_or:   result = d_msg.op_a | d_msg.op_b;
      alu_and:  result = d_msg.op_a & d_msg.op_b;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_val_q <= 1'b0;
    end else begin
      w_val_q <= d_val;
    end
  end

  // Tag rides along with the result
  always_ff @(posedge clk) begin
    if (d_val) begin
      w_msg_q <= '{seq: d_msg.seq, waddr: d_msg.waddr, wdata: result, wen: d_msg.wen};
    end
  end

  assign w_val = w_val_q;
  assign w_msg = w_msg_q;

endmodule

//--- hw/decode_issue.sv
`timescale 1ns/10ps
// Decode and in-order issue stage
// Register file written at commit, scoreboard of pending writes
// Reorder buffer occupancy and dispatch to the ALU or multiplier

module decode_issue
  import blimp_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inst_val,
  input  inst_u       inst,
  output logic        inst_rdy,
  input  logic        mul_rdy,
  input  logic        commit_val,
  input  commit_msg_t commit_msg,
  output logic        alu_val,
  output d_x_msg_t    alu_msg,
  output logic        mul_val,
  output d_x_msg_t    mul_msg
);

  logic [31:0]              rf_q [num_arch_regs];
  logic [num_arch_regs-1:0] pending_q;
  logic [seq_num_bits-1:0]  seq_q;
  logic [rob_cnt_bits-1:0]  in_flight_q;
  logic                     alu_val_q;
  logic                     mul_val_q;
  d_x_msg_t                 alu_msg_q;
  d_x_msg_t                 mul_msg_q;

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [11:0]              imm12;
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [reg_addr_bits-1:0] rd;
  logic                     is_op;
  logic                     is_op_imm;
  logic                     is_mul;
  logic                     is_shift;
  logic                     alt;
  logic                     legal;
  logic                     wen;
  alu_op_e                  op;
  logic [31:0]              op_a;
  logic [31:0]              op_b;
  logic                     hazard;
  logic                     rob_full;
  logic                     pipe_rdy;
  logic                     issue;
  d_x_msg_t                 d_msg;

  // --------------------
  // Decode
  // --------------------

  always_comb begin
    // Common fields sit at the same place in both views
    opcode    = inst.r_fmt.opcode;
    rd        = inst.i_fmt.rd;
    rs1       = inst.i_fmt.rs1;
    funct3    = inst.r_fmt.funct3;
    rs2       = inst.r_fmt.rs2;
    funct7    = inst.r_fmt.funct7;
    imm12     = inst.i_fmt.imm12;
    is_op     = (opcode == opc_op);
    is_op_imm = (opcode == opc_op_imm);
    is_mul    = is_op && (funct7 == funct7_muldiv) && (funct3 == f3_add_sub);
    is_shift  = (funct3 == f3_sll) || (funct3 == f3_srl_sra);
    // Bit 30 picks SUB and SRA
    alt       = funct7[5];
    case (funct3)
      f3_add_sub: op = (is_op && alt) ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      f3_and:     op = alu_and;
      default:    op = alu_add;
    endcase
    // Only MUL from the muldiv group
    if (is_op) begin
      legal = (funct7 == 7'b0) || is_mul ||
              ((funct7 == funct7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
    end else if (is_op_imm) begin
      if (funct3 == f3_sll) begin
        legal = (imm12[11:5] == 7'b0);
      end else if (funct3 == f3_srl_sra) begin
        legal = (imm12[11:5] == 7'b0) || (imm12[11:5] == funct7_alt);
      end else begin
        legal = 1'b1;
      end
    end else begin
      legal = 1'b0;
    end
    op_a = rf_q[rs1];
    if (is_op) begin
      op_b = rf_q[rs2];
    end else if (is_shift) begin
      op_b = {27'b0, imm12[4:0]};
    end else begin
      op_b = {{20{imm12[11]}}, imm12};
    end
    // Illegal word still flows to the ALU without a write
    if (!legal) begin
      op   = alu_add;
      op_a = '0;
      op_b = '0;
    end
    wen = legal && (rd != '0);
  end

  // --------------------
  // Issue check
  // --------------------

  always_comb begin
    // x0 never gets a pending bit
    hazard   = legal && (pending_q[rs1] || (is_op && pending_q[rs2]) || pending_q[rd]);
    rob_full = (in_flight_q == rob_cnt_bits'(rob_depth));
    // Multiplier is free only with no dispatch still waiting
    pipe_rdy = is_mul ? (mul_rdy && !mul_val_q) : 1'b1;
    inst_rdy = !rob_full && !hazard && pipe_rdy;
    issue    = inst_val && inst_rdy;
    d_msg    = '{seq: seq_q, op: op, op_a: op_a, op_b: op_b, waddr: rd, wen: wen};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        rf_q[i] <= '0;
      end
      pending_q   <= '0;
      seq_q       <= '0;
      in_flight_q <= '0;
      alu_val_q   <= 1'b0;
      mul_val_q   <= 1'b0;
    end else begin
      if (commit_val && commit_msg.wen) begin
        rf_q[commit_msg.waddr]      <= commit_msg.wdata;
        pending_q[commit_msg.waddr] <= 1'b0;
      end
      if (issue && wen) begin
        pending_q[rd] <= 1'b1;
      end
      if (issue) begin
        seq_q <= seq_q + 1'b1;
      end
      case ({issue, commit_val})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
      alu_val_q <= issue && !is_mul;
      // Held until the multiplier takes it
      if (issue && is_mul) begin
        mul_val_q <= 1'b1;
      end else if (mul_rdy) begin
        mul_val_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !is_mul) begin
      alu_msg_q <= d_msg;
    end
    if (issue && is_mul) begin
      mul_msg_q <= d_msg;
    end
  end

  assign alu_val = alu_val_q;
  assign alu_msg = alu_msg_q;
  assign mul_val = mul_val_q;
  assign mul_msg = mul_msg_q;

endmodule

//--- hw/blimp_pkg.sv
// Shared definitions for the core
// Sizes, RV32I encodings, instruction views, ALU op codes
// Message structs passed between decode, execute and commit

package blimp_pkg;

  // --------------------
  // Sizes
  // --------------------

  localparam int num_arch_regs = 32;
  localparam int reg_addr_bits = $clog2(num_arch_regs);
  localparam int rob_depth     = 8;
  localparam int seq_num_bits  = 3;
  // One extra bit so a full buffer is distinct from empty
  localparam int rob_cnt_bits  = seq_num_bits + 1;
  localparam int mul_iters     = 32;
  localparam int mul_cnt_bits  = $clog2(mul_iters);

  // --------------------
  // Encodings
  // --------------------

  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  // SUB and SRA/SRAI set bit 30
  localparam logic [6:0] funct7_alt    = 7'b0100000;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Register-register layout
  typedef struct packed {
    logic [6:0]               funct7;
    logic [reg_addr_bits-1:0] rs2;
    logic [reg_addr_bits-1:0] rs1;
    logic [2:0]               funct3;
    logic [reg_addr_bits-1:0] rd;
    logic [6:0]               opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0]              imm12;
    logic [reg_addr_bits-1:0] rs1;
    logic [2:0]               funct3;
    logic [reg_addr_bits-1:0] rd;
    logic [6:0]               opcode;
  } i_fmt_t;

  // Same 32-bit word, two decodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    alu_op_e                  op;
    logic [31:0]              op_a;
    logic [31:0]              op_b;
    logic [reg_addr_bits-1:0] waddr;
    logic                     wen;
  } d_x_msg_t;

  // Execute to writeback
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    logic [reg_addr_bits-1:0] waddr;
    logic [31:0]              wdata;
    logic                     wen;
  } x_w_msg_t;

  // Writeback to decode and trace
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    logic [reg_addr_bits-1:0] waddr;
    logic [31:0]              wdata;
    logic                     wen;
  } commit_msg_t;

endpackage
